// ==== rv_consts.svh ====
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

`define RV_XLEN       32
`define RV_NREG       32
`define RV_UART_ADDR  32'h20020
`define RV_DMEM_WORDS 256

// major opcodes
`define RV_OP_LUI     7'b0110111
`define RV_OP_AUIPC   7'b0010111
`define RV_OP_JAL     7'b1101111
`define RV_OP_JALR    7'b1100111
`define RV_OP_BRANCH  7'b1100011
`define RV_OP_LOAD    7'b0000011
`define RV_OP_STORE   7'b0100011
`define RV_OP_IMM     7'b0010011
`define RV_OP_REG     7'b0110011

// branch funct3
`define RV_F3_BEQ     3'b000
`define RV_F3_BNE     3'b001
`define RV_F3_BLT     3'b100
`define RV_F3_BGE     3'b101
`define RV_F3_BLTU    3'b110
`define RV_F3_BGEU    3'b111

// load/store funct3
`define RV_F3_B       3'b000
`define RV_F3_H       3'b001
`define RV_F3_W       3'b010
`define RV_F3_BU      3'b100
`define RV_F3_HU      3'b101

// alu funct3
`define RV_F3_ADD     3'b000
`define RV_F3_SLL     3'b001
`define RV_F3_SLT     3'b010
`define RV_F3_SLTU    3'b011
`define RV_F3_XOR     3'b100
`define RV_F3_SR      3'b101
`define RV_F3_OR      3'b110
`define RV_F3_AND     3'b111

`define RV_F7_BASE    7'b0000000
`define RV_F7_ALT     7'b0100000

// access size in rv_mem_req_t
`define RV_SIZE_B     2'd0
`define RV_SIZE_H     2'd1
`define RV_SIZE_W     2'd2

`endif

// ==== rv_pkg.sv ====
`include "rv_consts.svh"

package rv_pkg;

    typedef enum logic [5:0] {
        OP_NOP,
        OP_LUI, OP_AUIPC, OP_JAL, OP_JALR,
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
        OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU,
        OP_SB, OP_SH, OP_SW,
        OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI, OP_ANDI,
        OP_SLLI, OP_SRLI, OP_SRAI,
        OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU,
        OP_XOR, OP_SRL, OP_SRA, OP_OR, OP_AND
    } rv_op_e;

    typedef logic [`RV_XLEN-1:0] rv_word_t;
    typedef logic [$clog2(`RV_NREG)-1:0] rv_reg_t;
    typedef logic [7:0] uart_byte_t;

    typedef struct packed {
        rv_op_e   op;
        rv_reg_t  rd;
        rv_reg_t  rs1;
        rv_reg_t  rs2;
        rv_word_t imm;     // sign-extended for its format
        rv_word_t pc;
    } rv_dec_t;

    typedef struct packed {
        rv_word_t   addr;
        rv_word_t   store_data;
        logic       we;
        logic       re;
        logic [1:0] size;
        logic       unsigned_ld;
    } rv_mem_req_t;

    typedef struct packed {
        logic     en;
        rv_reg_t  rd;
        rv_word_t data;
    } rv_wb_t;

endpackage

// ==== rv_decode.sv ====
`include "rv_consts.svh"

module rv_decode
    import rv_pkg::*;
(
    input  rv_word_t i_inst,
    output rv_dec_t  o_dec
);

    logic [6:0] opcode;
    logic [2:0] f3;
    logic [6:0] f7;
    rv_word_t   imm_i;
    rv_word_t   imm_s;
    rv_word_t   imm_b;
    rv_word_t   imm_u;
    rv_word_t   imm_j;
    rv_op_e     op;

    assign opcode = i_inst[6:0];
    assign f3     = i_inst[14:12];
    assign f7     = i_inst[31:25];

    assign imm_i = {{20{i_inst[31]}}, i_inst[31:20]};
    assign imm_s = {{20{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
    assign imm_b = {{19{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
    assign imm_u = {i_inst[31:12], 12'b0};
    assign imm_j = {{11{i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

    always_comb begin
        op = OP_NOP;                                // fence, system, csr fall through
        case (opcode)
            `RV_OP_LUI:   op = OP_LUI;
            `RV_OP_AUIPC: op = OP_AUIPC;
            `RV_OP_JAL:   op = OP_JAL;
            `RV_OP_JALR:  op = (f3 == `RV_F3_ADD) ? OP_JALR : OP_NOP;
            `RV_OP_BRANCH: begin
                case (f3)
                    `RV_F3_BEQ:  op = OP_BEQ;
                    `RV_F3_BNE:  op = OP_BNE;
                    `RV_F3_BLT:  op = OP_BLT;
                    `RV_F3_BGE:  op = OP_BGE;
                    `RV_F3_BLTU: op = OP_BLTU;
                    `RV_F3_BGEU: op = OP_BGEU;
                    default:     op = OP_NOP;
                endcase
            end
            `RV_OP_LOAD: begin
                case (f3)
                    `RV_F3_B:  op = OP_LB;
                    `RV_F3_H:  op = OP_LH;
                    `RV_F3_W:  op = OP_LW;
                    `RV_F3_BU: op = OP_LBU;
                    `RV_F3_HU: op = OP_LHU;
                    default:   op = OP_NOP;
                endcase
            end
            `RV_OP_STORE: begin
                case (f3)
                    `RV_F3_B: op = OP_SB;
                    `RV_F3_H: op = OP_SH;
                    `RV_F3_W: op = OP_SW;
                    default:  op = OP_NOP;
                endcase
            end
            `RV_OP_IMM: begin
                case (f3)
                    `RV_F3_ADD:  op = OP_ADDI;
                    `RV_F3_SLT:  op = OP_SLTI;
                    `RV_F3_SLTU: op = OP_SLTIU;
                    `RV_F3_XOR:  op = OP_XORI;
                    `RV_F3_OR:   op = OP_ORI;
                    `RV_F3_AND:  op = OP_ANDI;
                    `RV_F3_SLL:  op = (f7 == `RV_F7_BASE) ? OP_SLLI : OP_NOP;
                    default:     op = (f7 == `RV_F7_BASE) ? OP_SRLI :
                                      (f7 == `RV_F7_ALT)  ? OP_SRAI : OP_NOP;
                endcase
            end
            `RV_OP_REG: begin
                if (f7 == `RV_F7_BASE) begin
                    case (f3)
                        `RV_F3_ADD:  op = OP_ADD;
                        `RV_F3_SLL:  op = OP_SLL;
                        `RV_F3_SLT:  op = OP_SLT;
                        `RV_F3_SLTU: op = OP_SLTU;
                        `RV_F3_XOR:  op = OP_XOR;
                        `RV_F3_SR:   op = OP_SRL;
                        `RV_F3_OR:   op = OP_OR;
                        default:     op = OP_AND;
                    endcase
                end else if (f7 == `RV_F7_ALT) begin
                    op = (f3 == `RV_F3_ADD) ? OP_SUB :
                         (f3 == `RV_F3_SR)  ? OP_SRA : OP_NOP;
                end
            end
            default: op = OP_NOP;
        endcase
    end

    always_comb begin
        o_dec     = '0;                             // pc filled in by the core
        o_dec.op  = op;
        o_dec.rd  = i_inst[11:7];
        o_dec.rs1 = i_inst[19:15];
        o_dec.rs2 = i_inst[24:20];
        case (opcode)
            `RV_OP_LUI, `RV_OP_AUIPC: o_dec.imm = imm_u;
            `RV_OP_JAL:    o_dec.imm = imm_j;
            `RV_OP_BRANCH: o_dec.imm = imm_b;
            `RV_OP_STORE:  o_dec.imm = imm_s;
            default:       o_dec.imm = imm_i;
        endcase
    end

endmodule

// ==== rv_regfile.sv ====
`include "rv_consts.svh"

module rv_regfile
    import rv_pkg::*;
(
    input  logic     clk,
    input  rv_reg_t  i_rs1,
    input  rv_reg_t  i_rs2,
    input  rv_wb_t   i_wb,
    output rv_word_t o_rs1_val,
    output rv_word_t o_rs2_val
);

    rv_word_t regs [1:`RV_NREG-1];                  // x0 is not stored

    always_ff @(posedge clk) begin
        if (i_wb.en && (i_wb.rd != '0)) begin
            regs[i_wb.rd] <= i_wb.data;
        end
    end

    function automatic rv_word_t read_port(input rv_reg_t rs);
        if (rs == '0) begin
            return '0;
        end else if (i_wb.en && (i_wb.rd == rs)) begin
            return i_wb.data;                       // bypass from execute
        end
        return regs[rs];
    endfunction

    always_comb begin
        o_rs1_val = read_port(i_rs1);
        o_rs2_val = read_port(i_rs2);
    end

endmodule

// ==== rv_execute.sv ====
`include "rv_consts.svh"

module rv_execute
    import rv_pkg::*;
(
    input  rv_dec_t     i_dec,
    input  rv_word_t    i_a,
    input  rv_word_t    i_b,
    output rv_word_t    o_result,
    output logic        o_wb_en,
    output logic        o_jump,
    output rv_word_t    o_jump_addr,
    output rv_mem_req_t o_mem,
    output logic        o_uart_pulse
);

    rv_word_t sum_ai;
    rv_word_t link;
    logic     eq;
    logic     lt_s;
    logic     lt_u;
    logic     uart_hit;
    logic [4:0] shamt;

    assign sum_ai   = i_a + i_dec.imm;              // also the load/store address
    assign link     = i_dec.pc + 32'd4;
    assign eq       = (i_a == i_b);
    assign lt_s     = ($signed(i_a) < $signed(i_b));
    assign lt_u     = (i_a < i_b);
    assign shamt    = i_dec.imm[4:0];
    assign uart_hit = (i_dec.op == OP_SB) && (sum_ai == `RV_UART_ADDR);

    always_comb begin
        o_result          = '0;
        o_wb_en           = 1'b0;
        o_jump            = 1'b0;
        o_jump_addr       = i_dec.pc + i_dec.imm;   // branch and jal target
        o_mem             = '0;
        o_mem.addr        = sum_ai;
        o_mem.store_data  = i_b;
        o_uart_pulse      = 1'b0;

        case (i_dec.op)
            OP_LUI:   begin o_result = i_dec.imm;            o_wb_en = 1'b1; end
            OP_AUIPC: begin o_result = i_dec.pc + i_dec.imm; o_wb_en = 1'b1; end
            OP_JAL: begin
                o_result = link;
                o_wb_en  = 1'b1;
                o_jump   = 1'b1;
            end
            OP_JALR: begin
                o_result    = link;
                o_wb_en     = 1'b1;
                o_jump      = 1'b1;
                o_jump_addr = {sum_ai[31:1], 1'b0};
            end
            OP_BEQ:  o_jump = eq;
            OP_BNE:  o_jump = !eq;
            OP_BLT:  o_jump = lt_s;
            OP_BGE:  o_jump = !lt_s;
            OP_BLTU: o_jump = lt_u;
            OP_BGEU: o_jump = !lt_u;
            OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU: begin
                o_result          = sum_ai;
                o_wb_en           = 1'b1;
                o_mem.re          = 1'b1;
                o_mem.unsigned_ld = (i_dec.op == OP_LBU) || (i_dec.op == OP_LHU);
                o_mem.size        = (i_dec.op == OP_LW) ? `RV_SIZE_W :
                                    (i_dec.op == OP_LH || i_dec.op == OP_LHU) ? `RV_SIZE_H :
                                    `RV_SIZE_B;
            end
            OP_SB: begin
                o_mem.we     = !uart_hit;           // uart byte never reaches memory
                o_mem.size   = `RV_SIZE_B;
                o_uart_pulse = uart_hit;
            end
            OP_SH: begin o_mem.we = 1'b1; o_mem.size = `RV_SIZE_H; end
            OP_SW: begin o_mem.we = 1'b1; o_mem.size = `RV_SIZE_W; end
            OP_ADDI:  begin o_result = sum_ai;                o_wb_en = 1'b1; end
            OP_SLTI:  begin
                o_result = {31'b0, $signed(i_a) < $signed(i_dec.imm)};
                o_wb_en  = 1'b1;
            end
            OP_SLTIU: begin o_result = {31'b0, i_a < i_dec.imm}; o_wb_en = 1'b1; end
            OP_XORI:  begin o_result = i_a ^ i_dec.imm;        o_wb_en = 1'b1; end
            OP_ORI:   begin o_result = i_a | i_dec.imm;        o_wb_en = 1'b1; end
            OP_ANDI:  begin o_result = i_a & i_dec.imm;        o_wb_en = 1'b1; end
            OP_SLLI:  begin o_result = i_a << shamt;           o_wb_en = 1'b1; end
            OP_SRLI:  begin o_result = i_a >> shamt;           o_wb_en = 1'b1; end
            OP_SRAI:  begin o_result = $signed(i_a) >>> shamt; o_wb_en = 1'b1; end
            OP_ADD:   begin o_result = i_a + i_b;              o_wb_en = 1'b1; end
            OP_SUB:   begin o_result = i_a - i_b;              o_wb_en = 1'b1; end
            OP_SLL:   begin o_result = i_a << i_b[4:0];        o_wb_en = 1'b1; end
            OP_SLT:   begin o_result = {31'b0, lt_s};          o_wb_en = 1'b1; end
            OP_SLTU:  begin o_result = {31'b0, lt_u};          o_wb_en = 1'b1; end
            OP_XOR:   begin o_result = i_a ^ i_b;              o_wb_en = 1'b1; end
            OP_SRL:   begin o_result = i_a >> i_b[4:0];        o_wb_en = 1'b1; end
            OP_SRA:   begin o_result = $signed(i_a) >>> i_b[4:0]; o_wb_en = 1'b1; end
            OP_OR:    begin o_result = i_a | i_b;              o_wb_en = 1'b1; end
            OP_AND:   begin o_result = i_a & i_b;              o_wb_en = 1'b1; end
            default: ;
        endcase
    end

    // a redirect must never carry a memory access along with it
    always_comb begin
        assert (!(o_jump && (o_mem.we || o_mem.re)))
            else $error("jump and memory request in one instruction");
    end

endmodule

// ==== rv_store_align.sv ====
`include "rv_consts.svh"

module rv_store_align
    import rv_pkg::*;
(
    input  rv_mem_req_t      i_mem,
    output logic [3:0]       o_lane_we,
    output uart_byte_t [3:0] o_lane_data,
    output logic [7:0]       o_word_idx
);

    logic [1:0] ofs;
    logic [4:0] shift;
    logic [3:0] mask;

    assign ofs = i_mem.addr[1:0];

    always_comb begin
        case (i_mem.size)
            `RV_SIZE_B: begin
                shift = {ofs, 3'b000};
                mask  = 4'b0001 << ofs;
            end
            `RV_SIZE_H: begin
                shift = {ofs[1], 4'b0000};          // halves sit on even lanes
                mask  = 4'b0011 << {ofs[1], 1'b0};
            end
            default: begin
                shift = 5'd0;
                mask  = 4'b1111;
            end
        endcase
    end

    assign o_lane_data = i_mem.store_data << shift;
    assign o_lane_we   = i_mem.we ? mask : 4'b0000;
    assign o_word_idx  = i_mem.addr[9:2];

endmodule

// ==== rv_byte_lane.sv ====
`include "rv_consts.svh"

module rv_byte_lane (
    input  logic       clk,
    input  logic       i_we,
    input  logic [7:0] i_idx,
    input  logic [7:0] i_data,
    output logic [7:0] o_data
);

    logic [7:0] mem [0:`RV_DMEM_WORDS-1];

    always_ff @(posedge clk) begin
        if (i_we) begin
            mem[i_idx] <= i_data;
        end
    end

    assign o_data = mem[i_idx];                     // async read

    a_idx_range: assert property (@(posedge clk) i_we |-> (int'(i_idx) < `RV_DMEM_WORDS));

endmodule

// ==== rv_load_extract.sv ====
`include "rv_consts.svh"

module rv_load_extract
    import rv_pkg::*;
(
    input  rv_mem_req_t      i_mem,
    input  uart_byte_t [3:0] i_lanes,
    output rv_word_t         o_load
);

    logic [1:0]  ofs;
    rv_word_t    word;
    uart_byte_t  b;
    logic [15:0] h;

    assign ofs  = i_mem.addr[1:0];
    assign word = i_lanes;                          // lane 3 is the top byte
    assign b    = i_lanes[ofs];
    assign h    = ofs[1] ? word[31:16] : word[15:0];

    always_comb begin
        case (i_mem.size)
            `RV_SIZE_B: o_load = i_mem.unsigned_ld ? {24'b0, b} : {{24{b[7]}}, b};
            `RV_SIZE_H: o_load = i_mem.unsigned_ld ? {16'b0, h} : {{16{h[15]}}, h};
            default:    o_load = word;
        endcase
    end

endmodule

// ==== rv_core.sv ====
module rv_core
    import rv_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    output rv_word_t   o_pc,
    input  rv_word_t   i_inst,
    output logic       o_uart_valid,
    output uart_byte_t o_uart_data
);

    rv_word_t         pc;
    rv_dec_t          dec_raw;
    rv_dec_t          dec_de;
    rv_dec_t          dec_ex;
    rv_word_t         rs1_val;
    rv_word_t         rs2_val;
    rv_word_t         a_ex;
    rv_word_t         b_ex;
    rv_word_t         result;
    rv_word_t         jump_addr;
    rv_word_t         load_data;
    logic             wb_en;
    logic             jump;
    logic             uart_pulse;
    rv_mem_req_t      mem;
    rv_wb_t           wb;
    logic [3:0]       lane_we;
    uart_byte_t [3:0] lane_wdata;
    uart_byte_t [3:0] lane_rdata;
    logic [7:0]       word_idx;

    assign o_pc = pc;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else begin
            pc <= jump ? jump_addr : pc + 32'd4;
        end
    end

    rv_decode rv_decode_inst (
        .i_inst (i_inst),
        .o_dec  (dec_raw)
    );

    always_comb begin
        dec_de    = dec_raw;
        dec_de.pc = pc;
    end

    rv_regfile rv_regfile_inst (
        .clk       (clk),
        .i_rs1     (dec_de.rs1),
        .i_rs2     (dec_de.rs2),
        .i_wb      (wb),
        .o_rs1_val (rs1_val),
        .o_rs2_val (rs2_val)
    );

    always_ff @(posedge clk) begin
        dec_ex <= dec_de;
        a_ex   <= rs1_val;
        b_ex   <= rs2_val;
        if (reset || jump) begin
            dec_ex.op <= OP_NOP;                    // squash the slot behind a jump
        end
    end

    rv_execute rv_execute_inst (
        .i_dec        (dec_ex),
        .i_a          (a_ex),
        .i_b          (b_ex),
        .o_result     (result),
        .o_wb_en      (wb_en),
        .o_jump       (jump),
        .o_jump_addr  (jump_addr),
        .o_mem        (mem),
        .o_uart_pulse (uart_pulse)
    );

    rv_store_align rv_store_align_inst (
        .i_mem       (mem),
        .o_lane_we   (lane_we),
        .o_lane_data (lane_wdata),
        .o_word_idx  (word_idx)
    );

    for (genvar i = 0; i < 4; i++) begin : g_lane
        rv_byte_lane rv_byte_lane_inst (
            .clk    (clk),
            .i_we   (lane_we[i]),
            .i_idx  (word_idx),
            .i_data (lane_wdata[i]),
            .o_data (lane_rdata[i])
        );
    end

    rv_load_extract rv_load_extract_inst (
        .i_mem   (mem),
        .i_lanes (lane_rdata),
        .o_load  (load_data)
    );

    always_comb begin
        wb.en   = wb_en;
        wb.rd   = dec_ex.rd;
        wb.data = mem.re ? load_data : result;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            o_uart_valid <= 1'b0;
        end else begin
            o_uart_valid <= uart_pulse;
        end
    end

    always_ff @(posedge clk) begin
        if (uart_pulse) begin
            o_uart_data <= mem.store_data[7:0];
        end
    end

endmodule

// ==== tb_rv_core.sv ====
`include "rv_consts.svh"

module tb_rv_core
    import rv_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int          NPROG  = 5;
    localparam int          MAXLEN = 128;
    localparam int          MAXEXP = 64;
    localparam logic [31:0] NOP    = 32'h00000013;

    logic       clk;
    logic       reset;
    rv_word_t   o_pc;
    rv_word_t   i_inst;
    logic       o_uart_valid;
    uart_byte_t o_uart_data;

    logic [31:0] prog [NPROG][MAXLEN];
    int          prog_len [NPROG];
    uart_byte_t  exp_bytes [NPROG][MAXEXP];
    int          exp_len [NPROG];
    int          bp;                                // program being built
    int          cur;                               // program being run
    int          rx_cnt;
    int          cycles = 0;
    int          limit;
    logic [31:0] rng;

    rv_core rv_core_inst (
        .clk          (clk),
        .reset        (reset),
        .o_pc         (o_pc),
        .i_inst       (i_inst),
        .o_uart_valid (o_uart_valid),
        .o_uart_data  (o_uart_data)
    );

    function automatic logic [31:0] itype(input int imm, input int rs1, input logic [2:0] f3,
                                          input int rd, input logic [6:0] opc);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], opc};
    endfunction

    function automatic logic [31:0] rtype(input logic [6:0] f7, input int rs2, input int rs1,
                                          input logic [2:0] f3, input int rd);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], `RV_OP_REG};
    endfunction

    function automatic logic [31:0] stype(input int imm, input int rs2, input int rs1,
                                          input logic [2:0] f3);
        return {imm[11:5], rs2[4:0], rs1[4:0], f3, imm[4:0], `RV_OP_STORE};
    endfunction

    function automatic logic [31:0] btype(input int imm, input int rs2, input int rs1,
                                          input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11], `RV_OP_BRANCH};
    endfunction

    function automatic logic [31:0] utype(input int imm, input int rd, input logic [6:0] opc);
        return {imm[31:12], rd[4:0], opc};
    endfunction

    function automatic logic [31:0] jtype(input int imm, input int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], `RV_OP_JAL};
    endfunction

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // load result as the ISA defines it, from a memory word
    function automatic rv_word_t expected_load(input logic [2:0] f3, input logic [1:0] ofs,
                                               input rv_word_t word);
        logic [7:0]  b;
        logic [15:0] h;
        b = 8'(word >> {ofs, 3'b000});
        h = 16'(word >> {ofs[1], 4'b0000});
        case (f3)
            `RV_F3_B:  return {{24{b[7]}}, b};
            `RV_F3_BU: return {24'b0, b};
            `RV_F3_H:  return {{16{h[15]}}, h};
            `RV_F3_HU: return {16'b0, h};
            default:   return word;
        endcase
    endfunction

    function automatic int pc_now();
        return prog_len[bp] * 4;
    endfunction

    function automatic logic [31:0] fetch_word(input rv_word_t pc);
        int idx;
        idx = int'(pc >> 2);
        if (idx < prog_len[cur]) begin
            return prog[cur][idx];
        end
        return NOP;                                 // past the end
    endfunction

    task automatic emit(input logic [31:0] w);
        prog[bp][prog_len[bp]] = w;
        prog_len[bp]++;
    endtask

    task automatic expect_byte(input uart_byte_t b);
        exp_bytes[bp][exp_len[bp]] = b;
        exp_len[bp]++;
    endtask

    task automatic send_reg(input int rs, input rv_word_t value);
        emit(stype(0, rs, 31, `RV_F3_B));           // sb rs, 0(x31)
        expect_byte(value[7:0]);
    endtask

    task automatic send_bad();
        emit(stype(0, 20, 31, `RV_F3_B));           // x20 holds 0xee, must never arrive
    endtask

    task automatic set_uart_base();
        emit(utype(`RV_UART_ADDR & 32'hFFFFF000, 31, `RV_OP_LUI));
        emit(itype(`RV_UART_ADDR & 32'h00000FFF, 31, `RV_F3_ADD, 31, `RV_OP_IMM));
    endtask

    task automatic branch_case(input logic [2:0] f3, input int rs1, input int rs2,
                               input logic taken, input uart_byte_t marker);
        emit(itype(marker, 0, `RV_F3_ADD, 21, `RV_OP_IMM));
        emit(btype(taken ? 12 : 8, rs2, rs1, f3));
        if (taken) begin
            send_bad();                             // flushed slot
            send_bad();                             // jumped over
        end
        send_reg(21, {24'b0, marker});
    endtask

    task automatic load_case(input logic [2:0] f3, input int addr, input rv_word_t word);
        rv_word_t value;
        value = expected_load(f3, addr[1:0], word);
        emit(itype(addr, 0, f3, 2, `RV_OP_LOAD));
        send_reg(2, value);                         // load-use through the bypass
        emit(itype(8, 2, `RV_F3_SR, 3, `RV_OP_IMM));
        send_reg(3, value >> 8);
        emit(itype(24, 2, `RV_F3_SR, 3, `RV_OP_IMM));
        send_reg(3, value >> 24);
    endtask

    task automatic build_alu();
        rv_word_t v [16];
        set_uart_base();
        rng = xorshift(rng);
        v[1] = {{20{rng[11]}}, rng[11:0]};
        emit(itype(v[1], 0, `RV_F3_ADD, 1, `RV_OP_IMM));
        rng = xorshift(rng);
        v[0] = {{20{rng[11]}}, rng[11:0]};
        v[2] = v[1] + v[0];
        emit(itype(v[0], 1, `RV_F3_ADD, 2, `RV_OP_IMM));
        send_reg(2, v[2]);
        v[3] = v[2] + v[1];
        emit(rtype(`RV_F7_BASE, 1, 2, `RV_F3_ADD, 3));
        send_reg(3, v[3]);
        v[4] = v[1] - v[3];
        emit(rtype(`RV_F7_ALT, 3, 1, `RV_F3_ADD, 4));
        send_reg(4, v[4]);
        v[5] = v[4] & v[2];
        emit(rtype(`RV_F7_BASE, 2, 4, `RV_F3_AND, 5));
        send_reg(5, v[5]);
        v[6] = v[5] | v[1];
        emit(rtype(`RV_F7_BASE, 1, 5, `RV_F3_OR, 6));
        send_reg(6, v[6]);
        v[7] = v[6] ^ v[3];
        emit(rtype(`RV_F7_BASE, 3, 6, `RV_F3_XOR, 7));
        send_reg(7, v[7]);
        v[8] = v[7] << 3;
        emit(itype(3, 7, `RV_F3_SLL, 8, `RV_OP_IMM));
        send_reg(8, v[8]);
        v[9] = $signed(v[8]) >>> 28;
        emit(itype(32'h400 | 28, 8, `RV_F3_SR, 9, `RV_OP_IMM));   // srai
        send_reg(9, v[9]);
        v[10] = v[8] >> 28;
        emit(itype(28, 8, `RV_F3_SR, 10, `RV_OP_IMM));
        send_reg(10, v[10]);
        v[11] = v[3] << v[10][4:0];
        emit(rtype(`RV_F7_BASE, 10, 3, `RV_F3_SLL, 11));
        send_reg(11, v[11]);
        v[12] = {31'b0, $signed(v[1]) < $signed(v[2])};
        emit(rtype(`RV_F7_BASE, 2, 1, `RV_F3_SLT, 12));
        send_reg(12, v[12]);
        v[13] = {31'b0, v[1] < v[2]};
        emit(rtype(`RV_F7_BASE, 2, 1, `RV_F3_SLTU, 13));
        send_reg(13, v[13]);
        emit(itype(32'h55, 0, `RV_F3_ADD, 0, `RV_OP_IMM));      // x0 stays zero
        send_reg(0, '0);
        emit(rtype(`RV_F7_BASE, 2, 1, `RV_F3_ADD, 0));
        send_reg(0, '0);
        emit(jtype(0, 0));
    endtask

    task automatic build_branch();
        int link;
        set_uart_base();
        emit(itype(32'hEE, 0, `RV_F3_ADD, 20, `RV_OP_IMM));
        emit(itype(32'hFFFFFFFB, 0, `RV_F3_ADD, 1, `RV_OP_IMM));  // -5
        emit(itype(3, 0, `RV_F3_ADD, 2, `RV_OP_IMM));
        emit(itype(3, 0, `RV_F3_ADD, 3, `RV_OP_IMM));
        branch_case(`RV_F3_BEQ, 2, 3, 1'b1, 8'h11);
        branch_case(`RV_F3_BEQ, 1, 2, 1'b0, 8'h12);
        branch_case(`RV_F3_BNE, 1, 2, 1'b1, 8'h13);
        branch_case(`RV_F3_BNE, 2, 3, 1'b0, 8'h14);
        branch_case(`RV_F3_BLT, 1, 2, 1'b1, 8'h15);
        branch_case(`RV_F3_BLT, 2, 1, 1'b0, 8'h16);
        branch_case(`RV_F3_BGE, 2, 1, 1'b1, 8'h17);
        branch_case(`RV_F3_BGE, 1, 2, 1'b0, 8'h18);
        branch_case(`RV_F3_BGE, 2, 3, 1'b1, 8'h19);
        branch_case(`RV_F3_BLTU, 2, 1, 1'b1, 8'h1A);
        branch_case(`RV_F3_BLTU, 1, 2, 1'b0, 8'h1B);
        branch_case(`RV_F3_BGEU, 1, 2, 1'b1, 8'h1C);
        branch_case(`RV_F3_BGEU, 2, 1, 1'b0, 8'h1D);
        link = pc_now() + 4;
        emit(jtype(12, 5));
        send_bad();
        send_bad();
        send_reg(5, link);
        link = pc_now() + 8;                        // auipc then jalr
        emit(utype(0, 6, `RV_OP_AUIPC));
        emit(itype(17, 6, `RV_F3_ADD, 7, `RV_OP_JALR));           // odd offset, bit 0 dropped
        send_bad();
        send_bad();
        send_reg(7, link);
        emit(jtype(0, 0));
    endtask

    task automatic build_load();
        set_uart_base();
        emit(utype(32'h9A856000, 1, `RV_OP_LUI));
        emit(itype(32'h234, 1, `RV_F3_ADD, 1, `RV_OP_IMM));
        emit(stype(32'h100, 1, 0, `RV_F3_W));
        load_case(`RV_F3_B, 32'h100, 32'h9A856234);
        load_case(`RV_F3_B, 32'h101, 32'h9A856234);
        load_case(`RV_F3_B, 32'h102, 32'h9A856234);
        load_case(`RV_F3_B, 32'h103, 32'h9A856234);
        load_case(`RV_F3_BU, 32'h102, 32'h9A856234);
        load_case(`RV_F3_BU, 32'h103, 32'h9A856234);
        load_case(`RV_F3_H, 32'h100, 32'h9A856234);
        load_case(`RV_F3_H, 32'h102, 32'h9A856234);
        load_case(`RV_F3_HU, 32'h100, 32'h9A856234);
        load_case(`RV_F3_HU, 32'h102, 32'h9A856234);
        load_case(`RV_F3_W, 32'h100, 32'h9A856234);
        emit(stype(32'h104, 0, 0, `RV_F3_W));
        emit(stype(32'h105, 1, 0, `RV_F3_B));
        emit(stype(32'h106, 1, 0, `RV_F3_H));
        load_case(`RV_F3_W, 32'h104, 32'h62343400);
        load_case(`RV_F3_HU, 32'h106, 32'h62343400);
        load_case(`RV_F3_B, 32'h105, 32'h62343400);
        emit(jtype(0, 0));
    endtask

    task automatic build_upper();
        rv_word_t v;
        set_uart_base();
        emit(utype(32'hABCDE000, 4, `RV_OP_LUI));
        emit(itype(12, 4, `RV_F3_SR, 5, `RV_OP_IMM));
        send_reg(5, 32'h000ABCDE);
        emit(itype(24, 4, `RV_F3_SR, 5, `RV_OP_IMM));
        send_reg(5, 32'h000000AB);
        v = 32'h12345000 + rv_word_t'(pc_now());
        emit(utype(32'h12345000, 6, `RV_OP_AUIPC));
        send_reg(6, v);
        emit(itype(12, 6, `RV_F3_SR, 7, `RV_OP_IMM));
        send_reg(7, v >> 12);
        emit(itype(24, 6, `RV_F3_SR, 7, `RV_OP_IMM));
        send_reg(7, v >> 24);
        emit(jtype(0, 0));
    endtask

    task automatic build_quiet();
        set_uart_base();
        emit(itype(32'h7A, 0, `RV_F3_ADD, 1, `RV_OP_IMM));
        emit(stype(1, 1, 31, `RV_F3_B));            // one byte above the uart address
        emit(stype(32'h24, 1, 0, `RV_F3_W));
        emit(itype(32'h24, 0, `RV_F3_W, 2, `RV_OP_LOAD));
        emit(stype(32'h20, 2, 0, `RV_F3_B));
        emit(jtype(0, 0));
    endtask

    task automatic check_uart(input uart_byte_t got, input uart_byte_t expected);
        if (got !== expected) begin
            $display("Fail o_uart_data: got %h expected %h", got, expected);
            $display("Verification failed");
            $fatal(1, "stopped at first error");
        end
    endtask

    task automatic check_count(input int got, input int expected);
        if (got != expected) begin
            $display("Fail uart byte count: got %h expected %h", got, expected);
            $display("Verification failed");
            $fatal(1, "stopped at first error");
        end
    endtask

    task automatic run_program(input int p);
        rv_word_t last;
        last = rv_word_t'(4 * (prog_len[p] - 1));   // the jal to itself
        @(posedge clk);
        #1 reset = 1'b1;
        @(negedge clk);
        cur    = p;
        rx_cnt = 0;
        repeat (8) @(posedge clk);
        #1 reset = 1'b0;
        while (o_pc != last) @(negedge clk);
        repeat (20) @(negedge clk);
        check_count(rx_cnt, exp_len[p]);
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        #1;
        i_inst = fetch_word(o_pc);                  // program memory, same-cycle return
    end

    always @(negedge clk) begin
        if (o_uart_valid) begin
            if (reset) begin
                $display("uart strobe seen while reset is asserted");
                $display("Verification failed");
                $fatal(1, "stopped at first error");
            end else if (rx_cnt >= exp_len[cur]) begin
                $display("unexpected extra uart byte %h in program %0d", o_uart_data, cur);
                $display("Verification failed");
                $fatal(1, "stopped at first error");
            end else begin
                check_uart(o_uart_data, exp_bytes[cur][rx_cnt]);
                rx_cnt++;
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles > limit) begin
            $display("timeout after %0d cycles, program %0d never settled", cycles, cur);
            $display("Verification failed");
            $fatal(1, "stopped at first error");
        end
    end

    initial begin
        reset  = 1'b1;
        i_inst = NOP;
        cur    = 0;
        rx_cnt = 0;
        limit  = 0;
        rng    = 32'h76005060;
        for (int p = 0; p < NPROG; p++) begin
            prog_len[p] = 0;
            exp_len[p]  = 0;
        end
        bp = 0;
        build_alu();
        bp = 1;
        build_branch();
        bp = 2;
        build_load();
        bp = 3;
        build_upper();
        bp = 4;
        build_quiet();
        for (int p = 0; p < NPROG; p++) begin
            limit += prog_len[p] * 4 + 40;
        end
        for (int p = 0; p < NPROG; p++) begin
            run_program(p);
        end
        $display("Verification passed");
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+.
rv_pkg.sv
rv_decode.sv
rv_regfile.sv
rv_execute.sv
rv_store_align.sv
rv_byte_lane.sv
rv_load_extract.sv
rv_core.sv
tb_rv_core.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/100ps \
    --top-module tb_rv_core -f compile.f -o tb_rv_core

./obj_dir/tb_rv_core
